//--- dv/alu_patterns.txt
// id instr rs_value rt_value expected_result expected_flags
// flags: bit2 zero, bit1 overflow, bit0 illegal
101 00000020 7fffffff 00000001 80000000 2  // add signed overflow
102 00000021 ffffffff 00000001 00000000 2  // addu carry out
103 00000022 80000000 00000001 7fffffff 2  // sub signed overflow
104 00000023 00000001 00000002 ffffffff 2  // subu borrow
105 00000020 00000005 00000003 00000008 0  // add
106 2000fffe 00000005 00000000 00000003 0  // addi negative imm
107 24000001 7fffffff 00000000 80000000 0  // addiu no carry
108 20000001 7fffffff 00000000 80000000 2  // addi signed overflow
201 00000024 ff00ff00 0ff00ff0 0f000f00 0  // and
202 00000025 ff00ff00 0ff00ff0 fff0fff0 0  // or
203 00000026 ff00ff00 0ff00ff0 f0f0f0f0 0  // xor
204 00000027 ff00ff00 0ff00ff0 000f000f 0  // nor
205 34008001 12340000 00000000 12348001 0  // ori zero-extended
206 30008000 ffffffff 00000000 00008000 0  // andi
207 3800ffff 0000ff00 00000000 000000ff 0  // xori
208 3c00abcd 00000000 00000000 abcd0000 0  // lui
209 00000100 00000000 8000000f 000000f0 0  // sll 4
20a 00000202 00000000 80000000 00800000 0  // srl 8
20b 000007c3 00000000 80000000 ffffffff 0  // sra 31
20c 00000004 00000020 00000001 00000000 4  // sllv by 32
20d 00000006 00000028 ffffffff 00000000 4  // srlv by 40
301 70000020 00000000 00000000 00000020 0  // clz of 0
302 70000020 00010000 00000000 0000000f 0  // clz
303 70000021 ffffffff 00000000 00000020 0  // clo of all ones
304 70000021 f0000000 00000000 00000004 0  // clo
305 0000002a ffffffff 00000001 00000001 0  // slt signed
306 0000002b ffffffff 00000001 00000000 4  // sltu
307 28000001 80000000 00000000 00000001 0  // slti
308 fc00fffe fffffffe 00000000 00000001 0  // seq equal
309 fc000006 00000005 00000000 00000000 4  // seq not equal
401 00000019 00001234 00000000 00000000 4  // multu by 0
402 00000012 00000000 00000000 00000000 4  // mflo
403 00000019 00010000 00030000 00000000 0  // multu into HI
404 00000010 00000000 00000000 00000003 0  // mfhi
405 00000018 ffffffff 00000002 fffffffe 0  // mult signed
406 00000012 00000000 00000000 fffffffe 0  // mflo
501 f8000000 00000001 00000002 00000000 5  // unknown opcode
502 0000003f 00000001 00000002 00000000 5  // unknown funct
503 00000010 00000000 00000000 ffffffff 0  // mfhi after illegal

//--- list.f
+incdir+common
common/isa_pkg.sv
common/alu_pkg.sv
decode/instr_decoder.sv
execute/overflow_detector.sv
execute/alu_core.sv
result/hilo_result.sv
verilog/alu_subsystem_top.sv
dv/alu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_tb
LOG       ?= sim.log
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/alu_tb.sv
`include "alu_defines.svh"

module alu_tb import alu_pkg::*, isa_pkg::*;;

  localparam int TIMEOUT   = 200;  // Cycles per handshake wait
  localparam int FIELDS    = 6;
  localparam int MAX_TESTS = 64;
  localparam logic [31:0] SEED = 32'hc9cd;

  logic   clk;
  logic   rst;
  logic   in_valid;
  logic   in_ready;
  instr_t instr;
  word_t  rs_value;
  word_t  rt_value;
  logic   out_valid;
  logic   out_ready;
  word_t  result;
  logic   zero;
  logic   overflow;
  logic   illegal;

  logic [31:0] pat_mem [0:MAX_TESTS*FIELDS-1];
  int          exp_q[$];  // Pattern indices in flight
  int          n_tests;
  int          pass_count;
  int          fail_count;
  int          other_errors;
  bit          stalled;
  bit          hold_low;
  bit          test_ok;
  string       tag;

  alu_subsystem_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .rs_value  (rs_value),
    .rt_value  (rt_value),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result),
    .zero      (zero),
    .overflow  (overflow),
    .illegal   (illegal)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    #1;
    if (hold_low) begin
      out_ready = 1'b0;
    end else begin
      out_ready = ($urandom % 10) < 7;  // About 70% ready
    end
  end

  function automatic logic [31:0] field(input int idx, input int col);
    return pat_mem[idx*FIELDS + col];
  endfunction

  function automatic string test_name(input int idx);
    logic [31:0] id;
    string       grp;
    id = field(idx, 0);
    case (id[11:8])
      4'h1:    grp = "arith";
      4'h2:    grp = "logic";
      4'h3:    grp = "count";
      4'h4:    grp = "hilo";
      4'h5:    grp = "illegal";
      default: grp = "misc";
    endcase
    return $sformatf("%s%s_%0d", tag, grp, id[7:0]);
  endfunction

  task automatic load_patterns();
    for (int i = 0; i < MAX_TESTS*FIELDS; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("dv/alu_patterns.txt", pat_mem);
    n_tests = 0;
    while (n_tests < MAX_TESTS && field(n_tests, 0) != 0) begin  // Id 0 ends the list
      n_tests++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      test_ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("%-20s %s", name, test_ok ? "ok" : "FAILED");
  endtask

  task automatic report_stall(input string msg);
    $display("%s", msg);
    stalled = 1'b1;
  endtask

  task automatic drive_item(input int idx);
    in_valid = 1'b1;
    instr    = field(idx, 1);
    rs_value = field(idx, 2);
    rt_value = field(idx, 3);
  endtask

  task automatic wait_accept(input int idx);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!in_ready && !stalled) begin
      waited++;
      if (waited >= TIMEOUT) begin
        report_stall("Timed out waiting for in_ready, the input handshake stalled.");
      end else begin
        @(negedge clk);
      end
    end
    if (!stalled) begin
      exp_q.push_back(idx);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic drive_all();
    for (int i = 0; i < n_tests && !stalled; i++) begin
      drive_item(i);
      wait_accept(i);
    end
  endtask

  task automatic check_result(input int idx);
    string name;
    name    = test_name(idx);
    test_ok = 1'b1;
    check_value({name, " result"}, field(idx, 4), result);
    check_value({name, " flags"}, field(idx, 5), {29'b0, zero, overflow, illegal});
    finish_test(name);
  endtask

  task automatic collect(input int count);
    int got;
    int waited;
    got = 0;
    while (got < count && !stalled) begin
      waited = 0;
      @(negedge clk);
      while (!(out_valid && out_ready) && !stalled) begin
        waited++;
        if (waited >= TIMEOUT) begin
          report_stall("Timed out waiting for out_valid, no result came out.");
        end else begin
          @(negedge clk);
        end
      end
      if (!stalled) begin
        if (exp_q.size() == 0) begin
          $display("A result came out with no instruction outstanding.");
          other_errors++;
        end else begin
          check_result(exp_q.pop_front());
        end
        got++;
      end
    end
  endtask

  // Out_ready held low so the three stages fill and in_ready drops
  task automatic fill_pipeline();
    int accepted;
    accepted = 0;
    tag      = "bp_";
    hold_low = 1'b1;
    @(posedge clk);
    #1;
    drive_item(0);
    @(negedge clk);
    while (in_ready && accepted < 8) begin
      exp_q.push_back(accepted);
      accepted++;
      @(posedge clk);
      #1;
      drive_item(accepted);
      @(negedge clk);
    end
    test_ok = 1'b1;
    check_value("bp_fill accepted", 32'd3, 32'(accepted));
    finish_test("bp_fill");
    hold_low = 1'b0;
    fork
      wait_accept(accepted);
      collect(accepted + 1);
    join
  endtask

  task automatic check_quiet();
    repeat (5) begin
      @(negedge clk);
      if (out_valid) begin
        $display("An extra result came out after all instructions had finished.");
        other_errors++;
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    in_valid     = 1'b0;
    instr        = '0;
    rs_value     = '0;
    rt_value     = '0;
    out_ready    = 1'b0;
    hold_low     = 1'b0;
    stalled      = 1'b0;
    pass_count   = 0;
    fail_count   = 0;
    other_errors = 0;
    tag          = "";
    void'($urandom(SEED));
    load_patterns();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      drive_all();
      collect(n_tests);
    join
    if (!stalled) begin
      fill_pipeline();
    end
    if (!stalled) begin
      check_quiet();
    end
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && other_errors == 0 && !stalled && n_tests > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog/alu_subsystem_top.sv
module alu_subsystem_top import isa_pkg::*, alu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   in_valid,
  output logic   in_ready,
  input  instr_t instr,
  input  word_t  rs_value,
  input  word_t  rt_value,
  output logic   out_valid,
  input  logic   out_ready,
  output word_t  result,
  output logic   zero,
  output logic   overflow,
  output logic   illegal
);

  // Decode to execute
  logic       dec_valid;
  logic       dec_ready;
  alu_sel_t   dec_sel;
  logic       dec_sign;
  word_t      dec_a;
  word_t      dec_b;
  logic [1:0] dec_hilo_op;
  logic       dec_illegal;

  // Execute to result
  logic       ex_valid;
  logic       ex_ready;
  dword_t     ex_result;
  logic       ex_zero;
  logic       ex_overflow;
  logic [1:0] ex_hilo_op;
  logic       ex_illegal;

  instr_decoder dec_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .instr       (instr),
    .rs_value    (rs_value),
    .rt_value    (rt_value),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_sel     (dec_sel),
    .dec_sign    (dec_sign),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_hilo_op (dec_hilo_op),
    .dec_illegal (dec_illegal)
  );

  alu_core alu_i (
    .clk         (clk),
    .rst         (rst),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_sel     (dec_sel),
    .dec_sign    (dec_sign),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_hilo_op (dec_hilo_op),
    .dec_illegal (dec_illegal),
    .ex_valid    (ex_valid),
    .ex_ready    (ex_ready),
    .ex_result   (ex_result),
    .ex_zero     (ex_zero),
    .ex_overflow (ex_overflow),
    .ex_hilo_op  (ex_hilo_op),
    .ex_illegal  (ex_illegal)
  );

  hilo_result res_i (
    .clk         (clk),
    .rst         (rst),
    .ex_valid    (ex_valid),
    .ex_ready    (ex_ready),
    .ex_result   (ex_result),
    .ex_zero     (ex_zero),
    .ex_overflow (ex_overflow),
    .ex_hilo_op  (ex_hilo_op),
    .ex_illegal  (ex_illegal),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .result      (result),
    .zero        (zero),
    .overflow    (overflow),
    .illegal     (illegal)
  );

endmodule

//--- result/hilo_result.sv
`include "alu_defines.svh"

module hilo_result import alu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       ex_valid,
  output logic       ex_ready,
  input  dword_t     ex_result,
  input  logic       ex_zero,
  input  logic       ex_overflow,
  input  logic [1:0] ex_hilo_op,
  input  logic       ex_illegal,
  output logic       out_valid,
  input  logic       out_ready,
  output word_t      result,
  output logic       zero,
  output logic       overflow,
  output logic       illegal
);

  word_t  hi;
  word_t  lo;
  logic   take;
  word_t  res_n;
  logic   zero_n;
  logic   ovf_n;

  assign ex_ready = !out_valid || out_ready;
  assign take     = ex_valid && ex_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      hi <= '0;
      lo <= '0;
    end else if (take && !ex_illegal && (ex_hilo_op == `HILO_WRITE)) begin
      hi <= ex_result[2*`ALU_XLEN-1:`ALU_XLEN];
      lo <= ex_result[`ALU_XLEN-1:0];
    end
  end

  always_comb begin
    res_n  = ex_result[`ALU_XLEN-1:0];
    zero_n = ex_zero;
    ovf_n  = ex_overflow;
    if (ex_illegal) begin
      res_n  = '0;
      zero_n = 1'b1;
      ovf_n  = 1'b0;
    end else if (ex_hilo_op == `HILO_RD_HI) begin
      res_n  = hi;
      zero_n = (hi == '0);
      ovf_n  = 1'b0;
    end else if (ex_hilo_op == `HILO_RD_LO) begin
      res_n  = lo;
      zero_n = (lo == '0);
      ovf_n  = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (ex_ready) begin
      out_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      result   <= res_n;
      zero     <= zero_n;
      overflow <= ovf_n;
      illegal  <= ex_illegal;
    end
  end

endmodule

//--- execute/alu_core.sv
`include "alu_defines.svh"

module alu_core import alu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       dec_valid,
  output logic       dec_ready,
  input  alu_sel_t   dec_sel,
  input  logic       dec_sign,
  input  word_t      dec_a,
  input  word_t      dec_b,
  input  logic [1:0] dec_hilo_op,
  input  logic       dec_illegal,
  output logic       ex_valid,
  input  logic       ex_ready,
  output dword_t     ex_result,
  output logic       ex_zero,
  output logic       ex_overflow,
  output logic [1:0] ex_hilo_op,
  output logic       ex_illegal
);

  localparam int HALF = `ALU_XLEN / 2;

  dword_t                  alu_res;
  dword_t                  prod_u;
  logic signed [2*`ALU_XLEN-1:0] prod_s;
  logic                    ovf;
  logic                    big_shift;
  logic                    msb_a;
  logic                    msb_b;

  // Binary search on halves, then quarters and so on
  function automatic logic [5:0] lead_zeros(input word_t v);
    logic [15:0] v16;
    logic [7:0]  v8;
    logic [3:0]  v4;
    logic [5:0]  n;
    n   = '0;
    v16 = '0;
    v8  = '0;
    v4  = '0;
    if (v == '0) begin
      n = 6'd32;
    end else begin
      n[4] = (v[31:16] == '0);
      v16  = n[4] ? v[15:0] : v[31:16];
      n[3] = (v16[15:8] == '0);
      v8   = n[3] ? v16[7:0] : v16[15:8];
      n[2] = (v8[7:4] == '0);
      v4   = n[2] ? v8[3:0] : v8[7:4];
      n[1] = (v4[3:2] == '0);
      n[0] = n[1] ? ~v4[1] : ~v4[3];
    end
    return n;
  endfunction

  overflow_detector ovf_det_i (
    .a        (dec_a),
    .b        (dec_b),
    .sel      (dec_sel),
    .sign     (dec_sign),
    .overflow (ovf)
  );

  assign prod_u    = dec_a * dec_b;
  assign prod_s    = $signed(dec_a) * $signed(dec_b);
  assign big_shift = dec_b >= word_t'(`ALU_XLEN);
  assign msb_a     = dec_a[`ALU_XLEN-1];
  assign msb_b     = dec_b[`ALU_XLEN-1];

  always_comb begin
    alu_res = '0;
    case (dec_sel)
      `ALU_SEL_ADD:  alu_res = {{`ALU_XLEN{1'b0}}, dec_a} + {{`ALU_XLEN{1'b0}}, dec_b};
      `ALU_SEL_SUB:  alu_res = {{`ALU_XLEN{1'b0}}, dec_a} - {{`ALU_XLEN{1'b0}}, dec_b};
      `ALU_SEL_MULT: begin
        if (dec_b != '0) begin
          alu_res = dec_sign ? dword_t'(prod_s) : prod_u;
        end
      end
      `ALU_SEL_LUI:  alu_res[`ALU_XLEN-1:0] = {dec_b[HALF-1:0], {HALF{1'b0}}};
      `ALU_SEL_SLL: begin
        if (!big_shift) begin
          alu_res[`ALU_XLEN-1:0] = dec_a << dec_b[4:0];
        end
      end
      `ALU_SEL_SRL: begin
        if (!big_shift) begin
          alu_res[`ALU_XLEN-1:0] = dec_a >> dec_b[4:0];
        end
      end
      `ALU_SEL_SRA:  alu_res[`ALU_XLEN-1:0] = $signed(dec_a) >>> dec_b[4:0];
      `ALU_SEL_AND:  alu_res[`ALU_XLEN-1:0] = dec_a & dec_b;
      `ALU_SEL_OR:   alu_res[`ALU_XLEN-1:0] = dec_a | dec_b;
      `ALU_SEL_XOR:  alu_res[`ALU_XLEN-1:0] = dec_a ^ dec_b;
      `ALU_SEL_NOR:  alu_res[`ALU_XLEN-1:0] = ~(dec_a | dec_b);
      `ALU_SEL_CLZ:  alu_res[5:0] = lead_zeros(dec_a);
      `ALU_SEL_CLO:  alu_res[5:0] = lead_zeros(~dec_a);  // Leading ones
      `ALU_SEL_SLT: begin
        if (dec_sign && (msb_a != msb_b)) begin
          alu_res[0] = msb_a;  // Negative A is less
        end else begin
          alu_res[0] = dec_a < dec_b;
        end
      end
      `ALU_SEL_SEQ:  alu_res[0] = (dec_a == dec_b);
      default:       alu_res = '0;
    endcase
  end

  assign dec_ready = !ex_valid || ex_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (dec_ready) begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid && dec_ready) begin
      ex_result   <= alu_res;
      ex_zero     <= (alu_res == '0);
      ex_overflow <= ovf;
      ex_hilo_op  <= dec_hilo_op;
      ex_illegal  <= dec_illegal;
    end
  end

endmodule

//--- execute/overflow_detector.sv
`include "alu_defines.svh"

module overflow_detector import alu_pkg::*; (
  input  word_t    a,
  input  word_t    b,
  input  alu_sel_t sel,
  input  logic     sign,
  output logic     overflow
);

  logic [`ALU_XLEN:0] sum;
  logic [`ALU_XLEN:0] diff;
  logic               msb_a;
  logic               msb_b;

  assign sum   = {1'b0, a} + {1'b0, b};
  assign diff  = {1'b0, a} - {1'b0, b};
  assign msb_a = a[`ALU_XLEN-1];
  assign msb_b = b[`ALU_XLEN-1];

  always_comb begin
    case (sel)
      `ALU_SEL_ADD: overflow = sign ? (msb_a == msb_b) && (sum[`ALU_XLEN-1] != msb_a)
                                    : sum[`ALU_XLEN];  // Carry out
      `ALU_SEL_SUB: overflow = sign ? (msb_a != msb_b) && (diff[`ALU_XLEN-1] != msb_a)
                                    : diff[`ALU_XLEN];  // Borrow
      default:      overflow = 1'b0;
    endcase
  end

endmodule

//--- decode/instr_decoder.sv
`include "alu_defines.svh"

module instr_decoder import isa_pkg::*, alu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  output logic       in_ready,
  input  instr_t     instr,
  input  word_t      rs_value,
  input  word_t      rt_value,
  output logic       dec_valid,
  input  logic       dec_ready,
  output alu_sel_t   dec_sel,
  output logic       dec_sign,
  output word_t      dec_a,
  output word_t      dec_b,
  output logic [1:0] dec_hilo_op,
  output logic       dec_illegal
);

  opcode_t    opcode;
  funct_t     funct;
  shamt_t     shamt;
  imm_t       imm;
  word_t      imm_sext;
  word_t      imm_zext;
  alu_sel_t   sel_n;
  logic       sign_n;
  word_t      a_n;
  word_t      b_n;
  logic [1:0] hilo_n;
  logic       illegal_n;

  assign opcode   = instr[31:26];
  assign funct    = instr[5:0];
  assign shamt    = instr[10:6];
  assign imm      = instr[15:0];
  assign imm_sext = {{(`ALU_XLEN-16){imm[15]}}, imm};
  assign imm_zext = {{(`ALU_XLEN-16){1'b0}}, imm};

  assign in_ready = !dec_valid || dec_ready;

  always_comb begin
    sel_n     = `ALU_SEL_ADD;
    sign_n    = 1'b0;
    a_n       = rs_value;
    b_n       = rt_value;
    hilo_n    = `HILO_NONE;
    illegal_n = 1'b0;
    case (opcode)
      `OPC_RTYPE: begin
        case (funct)
          `FUNCT_ADD:   begin sel_n = `ALU_SEL_ADD; sign_n = 1'b1; end
          `FUNCT_ADDU:  sel_n = `ALU_SEL_ADD;
          `FUNCT_SUB:   begin sel_n = `ALU_SEL_SUB; sign_n = 1'b1; end
          `FUNCT_SUBU:  sel_n = `ALU_SEL_SUB;
          `FUNCT_MULT:  begin sel_n = `ALU_SEL_MULT; sign_n = 1'b1; hilo_n = `HILO_WRITE; end
          `FUNCT_MULTU: begin sel_n = `ALU_SEL_MULT; hilo_n = `HILO_WRITE; end
          `FUNCT_AND:   sel_n = `ALU_SEL_AND;
          `FUNCT_OR:    sel_n = `ALU_SEL_OR;
          `FUNCT_XOR:   sel_n = `ALU_SEL_XOR;
          `FUNCT_NOR:   sel_n = `ALU_SEL_NOR;
          `FUNCT_SLT:   begin sel_n = `ALU_SEL_SLT; sign_n = 1'b1; end
          `FUNCT_SLTU:  sel_n = `ALU_SEL_SLT;
          `FUNCT_SLL:   begin sel_n = `ALU_SEL_SLL; a_n = rt_value; b_n = word_t'(shamt); end
          `FUNCT_SRL:   begin sel_n = `ALU_SEL_SRL; a_n = rt_value; b_n = word_t'(shamt); end
          `FUNCT_SRA:   begin sel_n = `ALU_SEL_SRA; a_n = rt_value; b_n = word_t'(shamt); end
          `FUNCT_SLLV:  begin sel_n = `ALU_SEL_SLL; a_n = rt_value; b_n = rs_value; end
          `FUNCT_SRLV:  begin sel_n = `ALU_SEL_SRL; a_n = rt_value; b_n = rs_value; end
          `FUNCT_SRAV:  begin sel_n = `ALU_SEL_SRA; a_n = rt_value; b_n = rs_value; end
          `FUNCT_MFHI:  hilo_n = `HILO_RD_HI;  // ALU value replaced later
          `FUNCT_MFLO:  hilo_n = `HILO_RD_LO;
          default:      illegal_n = 1'b1;
        endcase
      end
      `OPC_SPECIAL2: begin
        case (funct)
          `FUNCT_CLZ: sel_n = `ALU_SEL_CLZ;
          `FUNCT_CLO: sel_n = `ALU_SEL_CLO;
          default:    illegal_n = 1'b1;
        endcase
      end
      `OPC_ADDI:  begin sel_n = `ALU_SEL_ADD; sign_n = 1'b1; b_n = imm_sext; end
      `OPC_ADDIU: begin sel_n = `ALU_SEL_ADD; b_n = imm_sext; end
      `OPC_SLTI:  begin sel_n = `ALU_SEL_SLT; sign_n = 1'b1; b_n = imm_sext; end
      `OPC_SLTIU: begin sel_n = `ALU_SEL_SLT; b_n = imm_sext; end
      `OPC_ANDI:  begin sel_n = `ALU_SEL_AND; b_n = imm_zext; end
      `OPC_ORI:   begin sel_n = `ALU_SEL_OR; b_n = imm_zext; end
      `OPC_XORI:  begin sel_n = `ALU_SEL_XOR; b_n = imm_zext; end
      `OPC_LUI:   begin sel_n = `ALU_SEL_LUI; b_n = imm_zext; end
      `OPC_SEQ:   begin sel_n = `ALU_SEL_SEQ; b_n = imm_sext; end
      default:    illegal_n = 1'b1;
    endcase
    if (illegal_n) begin
      a_n = '0;  // Keeps the ALU quiet
      b_n = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (in_ready) begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      dec_sel     <= sel_n;
      dec_sign    <= sign_n;
      dec_a       <= a_n;
      dec_b       <= b_n;
      dec_hilo_op <= hilo_n;
      dec_illegal <= illegal_n;
    end
  end

endmodule

//--- common/alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

  typedef logic [`ALU_XLEN-1:0] word_t;

  typedef logic [2*`ALU_XLEN-1:0] dword_t;  // Full ALU result, HI:LO

  typedef logic [3:0] alu_sel_t;

endpackage

//--- common/isa_pkg.sv
`include "alu_defines.svh"

package isa_pkg;

  typedef logic [31:0] instr_t;

  typedef logic [5:0] opcode_t;  // instr[31:26]

  typedef logic [5:0] funct_t;   // instr[5:0]

  typedef logic [4:0] reg_idx_t;

  typedef logic [4:0] shamt_t;   // instr[10:6]

  typedef logic [15:0] imm_t;

endpackage

//--- common/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

`define ALU_XLEN 32

// ALU select codes
`define ALU_SEL_ADD  4'h0
`define ALU_SEL_SUB  4'h1
`define ALU_SEL_MULT 4'h2
`define ALU_SEL_LUI  4'h3
`define ALU_SEL_SLL  4'h4
`define ALU_SEL_SRL  4'h5
`define ALU_SEL_SRA  4'h7
`define ALU_SEL_AND  4'h8
`define ALU_SEL_OR   4'h9
`define ALU_SEL_XOR  4'hA
`define ALU_SEL_NOR  4'hB
`define ALU_SEL_CLZ  4'hC
`define ALU_SEL_CLO  4'hD
`define ALU_SEL_SLT  4'hE
`define ALU_SEL_SEQ  4'hF

`define HILO_NONE  2'd0
`define HILO_WRITE 2'd1
`define HILO_RD_HI 2'd2
`define HILO_RD_LO 2'd3

`define OPC_RTYPE    6'h00
`define OPC_ADDI     6'h08
`define OPC_ADDIU    6'h09
`define OPC_SLTI     6'h0A
`define OPC_SLTIU    6'h0B
`define OPC_ANDI     6'h0C
`define OPC_ORI      6'h0D
`define OPC_XORI     6'h0E
`define OPC_LUI      6'h0F
`define OPC_SPECIAL2 6'h1C  // clz/clo
`define OPC_SEQ      6'h3F  // Custom

`define FUNCT_SLL   6'h00
`define FUNCT_SRL   6'h02
`define FUNCT_SRA   6'h03
`define FUNCT_SLLV  6'h04
`define FUNCT_SRLV  6'h06
`define FUNCT_SRAV  6'h07
`define FUNCT_MFHI  6'h10
`define FUNCT_MFLO  6'h12
`define FUNCT_MULT  6'h18
`define FUNCT_MULTU 6'h19
`define FUNCT_ADD   6'h20
`define FUNCT_ADDU  6'h21
`define FUNCT_SUB   6'h22
`define FUNCT_SUBU  6'h23
`define FUNCT_AND   6'h24
`define FUNCT_OR    6'h25
`define FUNCT_XOR   6'h26
`define FUNCT_NOR   6'h27
`define FUNCT_SLT   6'h2A
`define FUNCT_SLTU  6'h2B
`define FUNCT_CLZ   6'h20  // Under OPC_SPECIAL2
`define FUNCT_CLO   6'h21

`endif
